//--- rtl/siudp_proto_pkg.sv
// UDP request protocol package with header layout, limits, addressing and opcodes
package siudp_proto_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [31:0] req_size_t;

    // First byte of every request
    typedef enum logic [7:0] {
        OP_READ  = 8'h01,
        OP_WRITE = 8'h02
    } siudp_op_e;

    // Opcode, then size and address, both MSB first
    localparam int HDR_BYTES = 9;

    // Read replies are split into packets of this size
    localparam int MAX_PAYLOAD = 16;

    // Write reply carries the byte count only
    localparam int CONFIRM_BYTES = 4;

    localparam ip_addr_t LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam udp_port_t LOCAL_PORT = 16'd1234;

endpackage

//--- rtl/siudp_bus_pkg.sv
// Register bus package with address and data widths and their types
package siudp_bus_pkg;

    localparam int BUS_ADDR_W = 32;
    localparam int BUS_DATA_W = 8;

    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [BUS_DATA_W-1:0] bus_data_t;

endpackage

//--- rtl/siudp_ifs.sv
// Request handler interfaces for the decoded command and the byte streams
`timescale 1ns/1ns

interface siudp_cmd_if;
    logic                       valid;
    siudp_proto_pkg::siudp_op_e op;
    siudp_bus_pkg::bus_addr_t   addr;
    siudp_proto_pkg::req_size_t size;
    siudp_proto_pkg::ip_addr_t  peer_ip;
    siudp_proto_pkg::udp_port_t peer_port;
    // Pulses on the final reply byte
    logic                       done;

    modport parser (
        output valid, op, addr, size, peer_ip, peer_port,
        input  done
    );

    modport engine (
        input valid, op, addr, size
    );

    modport framer (
        input  valid, op, addr, size, peer_ip, peer_port,
        output done
    );
endinterface

interface siudp_byte_if;
    logic                     valid;
    siudp_bus_pkg::bus_data_t data;
    logic                     ready;
    logic                     last;

    modport src (
        output valid, data, last,
        input  ready
    );

    modport snk (
        input  valid, data, last,
        output ready
    );
endinterface

//--- rtl/siudp_cmd_parser.sv
// Request parser that filters UDP payload, decodes the header and forwards write data
`timescale 1ns/1ns

module siudp_cmd_parser (
    input  logic                       clk_125mhz,
    input  logic                       rst_125mhz,
    input  siudp_proto_pkg::ip_addr_t  rx_dest_ip,
    input  siudp_proto_pkg::udp_port_t rx_dest_port,
    input  siudp_proto_pkg::ip_addr_t  rx_src_ip,
    input  siudp_proto_pkg::udp_port_t rx_src_port,
    input  siudp_bus_pkg::bus_data_t   rx_payload_data,
    input  logic                       rx_payload_valid,
    output logic                       rx_payload_ready,
    input  logic                       rx_payload_last,
    siudp_cmd_if.parser                cmd,
    siudp_byte_if.src                  wr
);

    typedef enum logic [1:0] {
        ST_HDR,
        ST_WDATA,
        ST_DROP,
        ST_WAIT_DONE
    } state_e;

    state_e     state;
    logic [3:0] hdr_cnt;
    logic       match;
    logic       beat;
    logic       hdr_end;

    assign match = (rx_dest_ip == siudp_proto_pkg::LOCAL_IP) &&
                   (rx_dest_port == siudp_proto_pkg::LOCAL_PORT);
    assign beat = rx_payload_valid && rx_payload_ready;
    assign hdr_end = (hdr_cnt == 4'(siudp_proto_pkg::HDR_BYTES - 1));

    // Write data goes straight through, throttled by the bus engine
    assign wr.valid = (state == ST_WDATA) && rx_payload_valid;
    assign wr.data = rx_payload_data;
    assign wr.last = rx_payload_last;

    always_comb begin
        case (state)
            ST_WDATA:     rx_payload_ready = wr.ready;
            ST_WAIT_DONE: rx_payload_ready = 1'b0;
            default:      rx_payload_ready = 1'b1;
        endcase
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state <= ST_HDR;
            hdr_cnt <= '0;
            cmd.valid <= 1'b0;
        end else begin
            if (cmd.done) begin
                cmd.valid <= 1'b0;
            end
            case (state)
                ST_HDR: begin
                    if (beat) begin
                        if (!match) begin
                            hdr_cnt <= '0;
                            if (!rx_payload_last) begin
                                state <= ST_DROP;
                            end
                        end else if (hdr_end) begin
                            hdr_cnt <= '0;
                            if (cmd.op == siudp_proto_pkg::OP_WRITE) begin
                                cmd.valid <= 1'b1;
                                state <= ST_WDATA;
                            end else if (cmd.op == siudp_proto_pkg::OP_READ) begin
                                cmd.valid <= 1'b1;
                                state <= rx_payload_last ? ST_WAIT_DONE : ST_DROP;
                            end else if (!rx_payload_last) begin
                                state <= ST_DROP;
                            end
                        end else if (rx_payload_last) begin
                            // Short frame gives no command
                            hdr_cnt <= '0;
                        end else begin
                            hdr_cnt <= hdr_cnt + 4'd1;
                        end
                    end
                end
                ST_WDATA: begin
                    if (beat && rx_payload_last) begin
                        state <= ST_WAIT_DONE;
                    end
                end
                ST_DROP: begin
                    // A read may still be replying while trailing bytes drain
                    if (beat && rx_payload_last) begin
                        state <= (cmd.valid && !cmd.done) ? ST_WAIT_DONE : ST_HDR;
                    end
                end
                default: begin
                    if (cmd.done) begin
                        state <= ST_HDR;
                    end
                end
            endcase
        end
    end

    // Header fields shift in MSB first
    always_ff @(posedge clk_125mhz) begin
        if (state == ST_HDR && beat && match) begin
            if (hdr_cnt == 4'd0) begin
                cmd.op <= siudp_proto_pkg::siudp_op_e'(rx_payload_data);
            end else if (hdr_cnt < 4'd5) begin
                cmd.size <= {cmd.size[23:0], rx_payload_data};
            end else begin
                cmd.addr <= {cmd.addr[23:0], rx_payload_data};
            end
            if (hdr_end) begin
                cmd.peer_ip <= rx_src_ip;
                cmd.peer_port <= rx_src_port;
            end
        end
    end

endmodule

//--- rtl/siudp_bus_engine.sv
// Bus engine running Wishbone classic byte cycles for read and write requests
`timescale 1ns/1ns

module siudp_bus_engine (
    input  logic                       clk_125mhz,
    input  logic                       rst_125mhz,
    siudp_cmd_if.engine                cmd,
    siudp_byte_if.snk                  wr,
    siudp_byte_if.src                  rd,
    output logic                       wr_done,
    output siudp_proto_pkg::req_size_t wr_count,
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic                       wb_we,
    output siudp_bus_pkg::bus_addr_t   wb_adr,
    output siudp_bus_pkg::bus_data_t   wb_dat_w,
    input  siudp_bus_pkg::bus_data_t   wb_dat_r,
    input  logic                       wb_ack
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RUN,
        ST_BUS,
        ST_HOLD,
        ST_FINISH
    } state_e;

    state_e                     state;
    siudp_proto_pkg::req_size_t cnt;

    assign wb_cyc = (state == ST_BUS);
    assign wb_stb = (state == ST_BUS);

    // Write byte is consumed together with its ack
    assign wr.ready = (state == ST_BUS) && wb_we && wb_ack;
    assign rd.valid = (state == ST_HOLD);
    assign wr_count = cnt;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state <= ST_IDLE;
            wb_we <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cmd.valid) begin
                        wb_we <= (cmd.op == siudp_proto_pkg::OP_WRITE);
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (!wb_we || wr.valid) begin
                        state <= ST_BUS;
                    end
                end
                ST_BUS: begin
                    if (wb_ack) begin
                        if (!wb_we) begin
                            state <= ST_HOLD;
                        end else if (wr.last) begin
                            wr_done <= 1'b1;
                            state <= ST_FINISH;
                        end else begin
                            state <= ST_RUN;
                        end
                    end
                end
                ST_HOLD: begin
                    // Next read waits until the framer takes this byte
                    if (rd.ready) begin
                        state <= rd.last ? ST_FINISH : ST_RUN;
                    end
                end
                ST_FINISH: begin
                    if (!cmd.valid) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (state == ST_IDLE && cmd.valid) begin
            wb_adr <= cmd.addr;
            cnt <= '0;
        end
        if (state == ST_RUN) begin
            wb_dat_w <= wr.data;
        end
        if (state == ST_BUS && wb_ack) begin
            wb_adr <= wb_adr + 1'b1;
            cnt <= cnt + 1'b1;
            rd.data <= wb_dat_r;
            rd.last <= (cnt + 1'b1 == cmd.size);
        end
    end

endmodule

//--- rtl/siudp_reply_framer.sv
// Reply framer that packs read data or the write count into UDP reply packets
`timescale 1ns/1ns

module siudp_reply_framer (
    input  logic                       clk_125mhz,
    input  logic                       rst_125mhz,
    siudp_cmd_if.framer                cmd,
    siudp_byte_if.snk                  rd,
    input  logic                       wr_done,
    input  siudp_proto_pkg::req_size_t wr_count,
    output logic                       tx_hdr_valid,
    input  logic                       tx_hdr_ready,
    output siudp_proto_pkg::ip_addr_t  tx_dest_ip,
    output siudp_proto_pkg::udp_port_t tx_dest_port,
    output siudp_proto_pkg::udp_port_t tx_src_port,
    output siudp_proto_pkg::udp_len_t  tx_length,
    output siudp_bus_pkg::bus_data_t   tx_payload_data,
    output logic                       tx_payload_valid,
    input  logic                       tx_payload_ready,
    output logic                       tx_payload_last
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR,
        ST_DATA
    } state_e;

    state_e                     state;
    siudp_proto_pkg::req_size_t remain;
    siudp_proto_pkg::udp_len_t  pkt_cnt;
    siudp_bus_pkg::bus_data_t   confirm_byte;
    logic                       is_rd;
    logic                       beat;
    logic                       final_beat;

    // Packet length is capped at the largest payload
    function automatic siudp_proto_pkg::udp_len_t pkt_len(
        input siudp_proto_pkg::req_size_t n
    );
        if (n > siudp_proto_pkg::MAX_PAYLOAD) begin
            return 16'(siudp_proto_pkg::MAX_PAYLOAD);
        end
        return n[15:0];
    endfunction

    assign is_rd = (cmd.op == siudp_proto_pkg::OP_READ);

    // Reply goes back to the requester
    assign tx_hdr_valid = (state == ST_HDR);
    assign tx_dest_ip = cmd.peer_ip;
    assign tx_dest_port = cmd.peer_port;
    assign tx_src_port = siudp_proto_pkg::LOCAL_PORT;

    always_comb begin
        case (pkt_cnt[1:0])
            2'd0:    confirm_byte = wr_count[31:24];
            2'd1:    confirm_byte = wr_count[23:16];
            2'd2:    confirm_byte = wr_count[15:8];
            default: confirm_byte = wr_count[7:0];
        endcase
    end

    assign tx_payload_valid = (state == ST_DATA) && (is_rd ? rd.valid : 1'b1);
    assign tx_payload_data = is_rd ? rd.data : confirm_byte;
    assign tx_payload_last = (pkt_cnt == tx_length - 1'b1);
    assign rd.ready = (state == ST_DATA) && is_rd && tx_payload_ready;

    assign beat = tx_payload_valid && tx_payload_ready;
    assign final_beat = is_rd ? rd.last : tx_payload_last;
    assign cmd.done = beat && final_beat;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wr_done || (cmd.valid && is_rd)) begin
                        state <= ST_HDR;
                    end
                end
                ST_HDR: begin
                    if (tx_hdr_ready) begin
                        state <= ST_DATA;
                    end
                end
                default: begin
                    if (beat && final_beat) begin
                        state <= ST_IDLE;
                    end else if (beat && tx_payload_last) begin
                        state <= ST_HDR;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_125mhz) begin
        case (state)
            ST_IDLE: begin
                remain <= cmd.size;
                tx_length <= is_rd ? pkt_len(cmd.size) :
                             16'(siudp_proto_pkg::CONFIRM_BYTES);
            end
            ST_HDR: begin
                pkt_cnt <= '0;
            end
            default: begin
                if (beat) begin
                    pkt_cnt <= pkt_cnt + 1'b1;
                    remain <= remain - 1'b1;
                    // Length of the following read packet
                    if (tx_payload_last) begin
                        tx_length <= pkt_len(remain - 1'b1);
                    end
                end
            end
        endcase
    end

endmodule

//--- rtl/siudp_top.sv
// UDP register access top level connecting parser, bus engine and reply framer
`timescale 1ns/1ns

module siudp_top (
    input  logic                       clk_125mhz,
    input  logic                       rst_125mhz,
    input  siudp_proto_pkg::ip_addr_t  rx_dest_ip,
    input  siudp_proto_pkg::udp_port_t rx_dest_port,
    input  siudp_proto_pkg::ip_addr_t  rx_src_ip,
    input  siudp_proto_pkg::udp_port_t rx_src_port,
    input  siudp_bus_pkg::bus_data_t   rx_payload_data,
    input  logic                       rx_payload_valid,
    output logic                       rx_payload_ready,
    input  logic                       rx_payload_last,
    output logic                       tx_hdr_valid,
    input  logic                       tx_hdr_ready,
    output siudp_proto_pkg::ip_addr_t  tx_dest_ip,
    output siudp_proto_pkg::udp_port_t tx_dest_port,
    output siudp_proto_pkg::udp_port_t tx_src_port,
    output siudp_proto_pkg::udp_len_t  tx_length,
    output siudp_bus_pkg::bus_data_t   tx_payload_data,
    output logic                       tx_payload_valid,
    input  logic                       tx_payload_ready,
    output logic                       tx_payload_last,
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic                       wb_we,
    output siudp_bus_pkg::bus_addr_t   wb_adr,
    output siudp_bus_pkg::bus_data_t   wb_dat_w,
    input  siudp_bus_pkg::bus_data_t   wb_dat_r,
    input  logic                       wb_ack
);

    siudp_proto_pkg::req_size_t wr_count;
    logic                       wr_done;

    siudp_cmd_if  cmd ();
    siudp_byte_if wr_stream ();
    siudp_byte_if rd_stream ();

    siudp_cmd_parser u_parser (
        .clk_125mhz       (clk_125mhz),
        .rst_125mhz       (rst_125mhz),
        .rx_dest_ip       (rx_dest_ip),
        .rx_dest_port     (rx_dest_port),
        .rx_src_ip        (rx_src_ip),
        .rx_src_port      (rx_src_port),
        .rx_payload_data  (rx_payload_data),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .rx_payload_last  (rx_payload_last),
        .cmd              (cmd.parser),
        .wr               (wr_stream.src)
    );

    siudp_bus_engine u_engine (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .cmd        (cmd.engine),
        .wr         (wr_stream.snk),
        .rd         (rd_stream.src),
        .wr_done    (wr_done),
        .wr_count   (wr_count),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack)
    );

    siudp_reply_framer u_framer (
        .clk_125mhz       (clk_125mhz),
        .rst_125mhz       (rst_125mhz),
        .cmd              (cmd.framer),
        .rd               (rd_stream.snk),
        .wr_done          (wr_done),
        .wr_count         (wr_count),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_dest_ip       (tx_dest_ip),
        .tx_dest_port     (tx_dest_port),
        .tx_src_port      (tx_src_port),
        .tx_length        (tx_length),
        .tx_payload_data  (tx_payload_data),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .tx_payload_last  (tx_payload_last)
    );

endmodule

//--- dv/siudp_tb.sv
// Testbench for the UDP register access handler with a Wishbone memory slave and a byte model
`timescale 1ns/1ns

module siudp_tb;

    localparam int MEM_SIZE = 1024;
    localparam int WAIT_LIMIT = 2000;

    typedef logic [7:0] byte_q [$];

    logic                       clk_125mhz;
    logic                       rst_125mhz;
    siudp_proto_pkg::ip_addr_t  rx_dest_ip;
    siudp_proto_pkg::udp_port_t rx_dest_port;
    siudp_proto_pkg::ip_addr_t  rx_src_ip;
    siudp_proto_pkg::udp_port_t rx_src_port;
    siudp_bus_pkg::bus_data_t   rx_payload_data;
    logic                       rx_payload_valid;
    logic                       rx_payload_ready;
    logic                       rx_payload_last;
    logic                       tx_hdr_valid;
    logic                       tx_hdr_ready;
    siudp_proto_pkg::ip_addr_t  tx_dest_ip;
    siudp_proto_pkg::udp_port_t tx_dest_port;
    siudp_proto_pkg::udp_port_t tx_src_port;
    siudp_proto_pkg::udp_len_t  tx_length;
    siudp_bus_pkg::bus_data_t   tx_payload_data;
    logic                       tx_payload_valid;
    logic                       tx_payload_ready;
    logic                       tx_payload_last;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    siudp_bus_pkg::bus_addr_t   wb_adr;
    siudp_bus_pkg::bus_data_t   wb_dat_w;
    siudp_bus_pkg::bus_data_t   wb_dat_r;
    logic                       wb_ack;

    logic [7:0] mem [MEM_SIZE];
    logic [7:0] model [MEM_SIZE];
    integer     seed = 73639;
    int         ack_wait = -1;
    int         errors = 0;
    int         errors_at_start = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    logic       stress = 1'b0;

    siudp_top dut (.*);

    always #4 clk_125mhz = ~clk_125mhz;

    function automatic int pick(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // Wishbone slave backed by mem with an ack after 0 to 3 wait cycles
    always @(negedge clk_125mhz) begin
        if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (ack_wait < 0) begin
                ack_wait = pick(0, 3);
            end
            if (ack_wait == 0) begin
                if (wb_we) begin
                    mem[wb_adr[9:0]] = wb_dat_w;
                end else begin
                    wb_dat_r = mem[wb_adr[9:0]];
                end
                wb_ack = 1'b1;
            end
            ack_wait--;
        end
    end

    // Reply side back-pressure
    always @(negedge clk_125mhz) begin
        if (stress) begin
            tx_hdr_ready = (pick(0, 3) != 0);
            tx_payload_ready = (pick(0, 2) != 0);
        end else begin
            tx_hdr_ready = 1'b1;
            tx_payload_ready = 1'b1;
        end
    end

    task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR @%0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
        errors++;
    endtask

    function automatic byte_q make_header(input logic [7:0] op, input logic [31:0] size,
                                          input logic [31:0] addr);
        byte_q q;
        int    i;
        q.push_back(op);
        for (i = 3; i >= 0; i--) begin
            q.push_back(size[8*i +: 8]);
        end
        for (i = 3; i >= 0; i--) begin
            q.push_back(addr[8*i +: 8]);
        end
        return q;
    endfunction

    task automatic send_frame(input siudp_proto_pkg::ip_addr_t dip,
                              input siudp_proto_pkg::udp_port_t dport,
                              input siudp_proto_pkg::ip_addr_t sip,
                              input siudp_proto_pkg::udp_port_t sport,
                              input byte_q bytes);
        int   t;
        int   gap;
        logic took;
        @(negedge clk_125mhz);
        rx_dest_ip = dip;
        rx_dest_port = dport;
        rx_src_ip = sip;
        rx_src_port = sport;
        foreach (bytes[i]) begin
            gap = stress ? pick(0, 2) : 0;
            if (gap > 0) begin
                rx_payload_valid = 1'b0;
                repeat (gap) @(negedge clk_125mhz);
            end
            rx_payload_valid = 1'b1;
            rx_payload_data = bytes[i];
            rx_payload_last = (i == bytes.size() - 1);
            t = 0;
            took = 1'b0;
            while (!took && t < WAIT_LIMIT) begin
                @(posedge clk_125mhz);
                took = rx_payload_ready;
                t++;
            end
            @(negedge clk_125mhz);
            if (!took) begin
                rx_payload_valid = 1'b0;
                report_timeout("rx_payload_ready");
                return;
            end
        end
        rx_payload_valid = 1'b0;
        rx_payload_last = 1'b0;
    endtask

    // Expected packets follow from the byte list split at MAX_PAYLOAD
    task automatic collect_reply(input siudp_proto_pkg::ip_addr_t sip,
                                 input siudp_proto_pkg::udp_port_t sport,
                                 input byte_q exp);
        int                         idx;
        int                         len;
        int                         k;
        int                         t;
        logic                       seen;
        logic [7:0]                 got_data;
        logic                       got_last;
        siudp_proto_pkg::udp_len_t  got_len;
        siudp_proto_pkg::ip_addr_t  got_ip;
        siudp_proto_pkg::udp_port_t got_dport;
        siudp_proto_pkg::udp_port_t got_sport;
        idx = 0;
        while (idx < exp.size()) begin
            t = 0;
            seen = 1'b0;
            while (!seen && t < WAIT_LIMIT) begin
                @(posedge clk_125mhz);
                seen = tx_hdr_valid && tx_hdr_ready;
                got_len = tx_length;
                got_ip = tx_dest_ip;
                got_dport = tx_dest_port;
                got_sport = tx_src_port;
                t++;
            end
            if (!seen) begin
                report_timeout("a reply header");
                return;
            end
            len = exp.size() - idx;
            if (len > siudp_proto_pkg::MAX_PAYLOAD) begin
                len = siudp_proto_pkg::MAX_PAYLOAD;
            end
            expect_eq("tx_length", 32'(got_len), 32'(len));
            expect_eq("tx_dest_ip", got_ip, sip);
            expect_eq("tx_dest_port", 32'(got_dport), 32'(sport));
            expect_eq("tx_src_port", 32'(got_sport), 32'(siudp_proto_pkg::LOCAL_PORT));
            for (k = 0; k < len; k++) begin
                t = 0;
                seen = 1'b0;
                while (!seen && t < WAIT_LIMIT) begin
                    @(posedge clk_125mhz);
                    seen = tx_payload_valid && tx_payload_ready;
                    got_data = tx_payload_data;
                    got_last = tx_payload_last;
                    t++;
                end
                if (!seen) begin
                    report_timeout("a reply payload byte");
                    return;
                end
                expect_eq("reply byte", 32'(got_data), 32'(exp[idx]));
                expect_eq("tx_payload_last", 32'(got_last), 32'(k == len - 1));
                idx++;
            end
        end
    endtask

    task automatic write_request(input int n);
        byte_q                      frame;
        byte_q                      reply;
        logic [31:0]                addr;
        siudp_proto_pkg::ip_addr_t  sip;
        siudp_proto_pkg::udp_port_t sport;
        int                         i;
        addr = 32'(pick(0, MEM_SIZE - n));
        sip = 32'($random(seed));
        sport = 16'(pick(1024, 65535));
        frame = make_header(8'(siudp_proto_pkg::OP_WRITE), 32'(n), addr);
        for (i = 0; i < n; i++) begin
            frame.push_back(8'(pick(0, 255)));
            model[int'(addr) + i] = frame[siudp_proto_pkg::HDR_BYTES + i];
        end
        // Count of written bytes in high byte first order
        for (i = 3; i >= 0; i--) begin
            reply.push_back(8'(n >> (8 * i)));
        end
        fork
            send_frame(siudp_proto_pkg::LOCAL_IP, siudp_proto_pkg::LOCAL_PORT, sip, sport, frame);
            collect_reply(sip, sport, reply);
        join
    endtask

    task automatic read_request(input int n);
        byte_q                      frame;
        byte_q                      reply;
        logic [31:0]                addr;
        siudp_proto_pkg::ip_addr_t  sip;
        siudp_proto_pkg::udp_port_t sport;
        int                         i;
        addr = 32'(pick(0, MEM_SIZE - n));
        sip = 32'($random(seed));
        sport = 16'(pick(1024, 65535));
        frame = make_header(8'(siudp_proto_pkg::OP_READ), 32'(n), addr);
        for (i = 0; i < n; i++) begin
            reply.push_back(model[int'(addr) + i]);
        end
        fork
            send_frame(siudp_proto_pkg::LOCAL_IP, siudp_proto_pkg::LOCAL_PORT, sip, sport, frame);
            collect_reply(sip, sport, reply);
        join
    endtask

    // Frame that the DUT must drop without touching bus or reply side
    task automatic ignored_frame(input siudp_proto_pkg::ip_addr_t dip,
                                 input siudp_proto_pkg::udp_port_t dport,
                                 input logic [7:0] op);
        byte_q frame;
        int    hdrs;
        int    cycs;
        frame = make_header(op, 32'd4, 32'(pick(0, MEM_SIZE - 4)));
        repeat (4) frame.push_back(8'(pick(0, 255)));
        hdrs = 0;
        cycs = 0;
        fork
            send_frame(dip, dport, 32'($random(seed)), 16'(pick(1024, 65535)), frame);
            begin
                repeat (200) begin
                    @(posedge clk_125mhz);
                    if (tx_hdr_valid) begin
                        hdrs++;
                    end
                    if (wb_cyc) begin
                        cycs++;
                    end
                end
            end
        join
        assert (hdrs == 0 && cycs == 0) else begin
            $display("ERROR @%0t: dropped frame gave %0d header and %0d bus cycles",
                     $time, hdrs, cycs);
            errors++;
        end
    endtask

    task automatic compare_memory();
        int bad;
        bad = 0;
        foreach (mem[i]) begin
            if (mem[i] !== model[i]) begin
                bad++;
            end
        end
        assert (bad == 0) else begin
            $display("ERROR @%0t: %0d memory bytes differ from the model", $time, bad);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin
        int i;
        clk_125mhz = 1'b0;
        rst_125mhz = 1'b1;
        rx_dest_ip = '0;
        rx_dest_port = '0;
        rx_src_ip = '0;
        rx_src_port = '0;
        rx_payload_data = '0;
        rx_payload_valid = 1'b0;
        rx_payload_last = 1'b0;
        tx_hdr_ready = 1'b1;
        tx_payload_ready = 1'b1;
        wb_dat_r = '0;
        wb_ack = 1'b0;
        for (i = 0; i < MEM_SIZE; i++) begin
            mem[i] = 8'((i * 29) ^ (i >> 5));
            model[i] = mem[i];
        end
        repeat (5) @(negedge clk_125mhz);
        rst_125mhz = 1'b0;

        expect_eq("wb_cyc after reset", 32'(wb_cyc), 32'd0);
        expect_eq("wb_stb after reset", 32'(wb_stb), 32'd0);
        expect_eq("tx_hdr_valid after reset", 32'(tx_hdr_valid), 32'd0);
        expect_eq("tx_payload_valid after reset", 32'(tx_payload_valid), 32'd0);
        expect_eq("rx_payload_ready after reset", 32'(rx_payload_ready), 32'd1);
        finish_test("reset values");

        repeat (4) write_request(pick(1, 60));
        compare_memory();
        finish_test("write requests");

        // At least one read that needs several packets
        read_request(pick(17, 60));
        repeat (4) read_request(pick(1, 60));
        finish_test("read requests");

        ignored_frame(siudp_proto_pkg::LOCAL_IP, 16'(siudp_proto_pkg::LOCAL_PORT + 1),
                      8'(siudp_proto_pkg::OP_WRITE));
        ignored_frame(siudp_proto_pkg::LOCAL_IP ^ 32'h1, siudp_proto_pkg::LOCAL_PORT,
                      8'(siudp_proto_pkg::OP_WRITE));
        ignored_frame(siudp_proto_pkg::LOCAL_IP, siudp_proto_pkg::LOCAL_PORT, 8'h07);
        compare_memory();
        finish_test("filtered frames");

        stress = 1'b1;
        repeat (20) begin
            if (pick(0, 1) == 1) begin
                write_request(pick(1, 60));
            end else begin
                read_request(pick(1, 60));
            end
        end
        compare_memory();
        stress = 1'b0;
        finish_test("mixed requests under stress");

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
rtl/siudp_proto_pkg.sv
rtl/siudp_bus_pkg.sv
rtl/siudp_ifs.sv
rtl/siudp_cmd_parser.sv
rtl/siudp_bus_engine.sv
rtl/siudp_reply_framer.sv
rtl/siudp_top.sv
dv/siudp_tb.sv

//--- run.sh
#!/bin/bash
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module siudp_tb -o siudp_sim

output=$(./obj_dir/siudp_sim)
echo "$output"

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
